// File: source/mera_consts.svh
`ifndef MERA_CONSTS_SVH
`define MERA_CONSTS_SVH

// --------------------------------------------------
// system bus population
// --------------------------------------------------

// memory modules hanging on the bus
`define N_MODULES 4

// storage frames held by one module
`define MODULE_FRAMES 2

// words per frame, fixed by the 12-bit offset
`define FRAME_WORDS 4096

// cycles to wait for an answer before the alarm
`define BUS_TIMEOUT 16

// --------------------------------------------------
// AXI4-Lite side
// --------------------------------------------------

`define AXIL_AW 32
`define AXIL_DW 32

`endif

// File: source/elwro_bus_pkg.sv
package elwro_bus_pkg;

	// --------------------------------------------------
	// address word, two views of the same 16 bits
	// --------------------------------------------------

	// memory cycle: page and offset inside segment nb
	typedef struct packed {
		logic [3:0]  page;
		logic [11:0] offset;
	} mem_addr_s;

	// configuration cycle: which module and frame to touch
	typedef struct packed {
		logic [3:0] module_num;
		logic [3:0] frame_num;
		logic       unmap;
		logic [6:0] reserved;
	} cfg_cmd_s;

	// decoded by the io flag of the cycle
	typedef union packed {
		mem_addr_s mem;
		cfg_cmd_s  cfg;
	} bus_addr_u;

	// --------------------------------------------------
	// bus cycle and answer
	// --------------------------------------------------

	// one cycle, strobe high for a single clock
	typedef struct packed {
		logic      strobe;
		logic      w;
		logic      r;
		logic      io;
		logic [3:0] nb;
		bus_addr_u ad;
		logic [15:0] dt;
	} bus_req_s;

	// answer of one module, dt is zero unless it returns read data
	typedef struct packed {
		logic        ok;
		logic [15:0] dt;
	} bus_rsp_s;

	// data word of a configuration write
	typedef struct packed {
		logic [3:0] segment;
		logic [3:0] page;
		logic [7:0] reserved;
	} cfg_data_s;

endpackage

// File: source/axil_pkg.sv
`include "mera_consts.svh"

package axil_pkg;

	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// master to slave
	typedef struct packed {
		logic [`AXIL_AW-1:0]   awaddr;
		logic                  awvalid;
		logic [`AXIL_DW-1:0]   wdata;
		logic [`AXIL_DW/8-1:0] wstrb;
		logic                  wvalid;
		logic                  bready;
		logic [`AXIL_AW-1:0]   araddr;
		logic                  arvalid;
		logic                  rready;
	} axil_req_s;

	// slave to master
	typedef struct packed {
		logic                awready;
		logic                wready;
		axil_resp_e          bresp;
		logic                bvalid;
		logic                arready;
		logic [`AXIL_DW-1:0] rdata;
		axil_resp_e          rresp;
		logic                rvalid;
	} axil_rsp_s;

endpackage

// File: source/bus_master.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module bus_master (
	input  logic                     clk,
	input  logic                     rst,
	input  axil_pkg::axil_req_s      axil_in,
	output axil_pkg::axil_rsp_s      axil_out,
	output elwro_bus_pkg::bus_req_s  req,
	input  logic                     rsp_done,
	input  logic                     rsp_ok,
	input  logic [15:0]              rsp_dt
);

	import axil_pkg::*;
	import elwro_bus_pkg::*;

	// init only keeps the ready outputs low through reset
	typedef enum logic [1:0] {
		S_INIT,
		S_IDLE,
		S_WAIT,
		S_RESP
	} state_e;

	state_e state;
	logic wr_acc;
	logic rd_acc;
	logic [`AXIL_AW-1:0] acc_addr;
	// captured bus cycle
	logic strobe_q;
	logic is_wr_q;
	logic io_q;
	logic [3:0] nb_q;
	bus_addr_u ad_q;
	logic [15:0] dt_q;
	// held answer for back-pressure
	logic resp_ok_q;
	logic [15:0] resp_dt_q;
	logic resp_ok;
	logic [15:0] resp_dt;
	logic resp_valid;
	logic resp_taken;

	// --------------------------------------------------
	// accept
	// --------------------------------------------------

	// write needs both channels, and beats a read
	assign wr_acc = (state == S_IDLE) & axil_in.awvalid & axil_in.wvalid;
	assign rd_acc = (state == S_IDLE) & axil_in.arvalid & ~wr_acc;
	assign acc_addr = wr_acc ? axil_in.awaddr : axil_in.araddr;

	assign axil_out.awready = wr_acc;
	assign axil_out.wready = wr_acc;
	assign axil_out.arready = (state == S_IDLE) & ~(axil_in.awvalid & axil_in.wvalid);

	// byte address: io at 22, nb at 21..18, word at 17..2
	always_ff @(posedge clk) begin
		if (wr_acc | rd_acc) begin
			is_wr_q <= wr_acc;
			io_q <= acc_addr[22];
			nb_q <= acc_addr[21:18];
			ad_q <= bus_addr_u'(acc_addr[17:2]);
			dt_q <= axil_in.wdata[15:0];
		end
	end

	assign req = '{
		strobe: strobe_q,
		w: is_wr_q,
		r: ~is_wr_q,
		io: io_q,
		nb: nb_q,
		ad: ad_q,
		dt: dt_q
	};

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_INIT;
			strobe_q <= 1'b0;
		end else begin
			// one clock of strobe per accepted access
			strobe_q <= wr_acc | rd_acc;
			case (state)
				S_INIT: state <= S_IDLE;
				S_IDLE: if (wr_acc | rd_acc) state <= S_WAIT;
				// answer may be taken in the same cycle it shows up
				S_WAIT: if (rsp_done) state <= resp_taken ? S_IDLE : S_RESP;
				S_RESP: if (resp_taken) state <= S_IDLE;
				default: state <= S_INIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == S_WAIT) & rsp_done) begin
			resp_ok_q <= rsp_ok;
			resp_dt_q <= rsp_dt;
		end
	end

	// --------------------------------------------------
	// response
	// --------------------------------------------------

	// first cycle comes straight from the collector, then from the hold regs
	assign resp_valid = ((state == S_WAIT) & rsp_done) | (state == S_RESP);
	assign resp_ok = (state == S_RESP) ? resp_ok_q : rsp_ok;
	assign resp_dt = (state == S_RESP) ? resp_dt_q : rsp_dt;
	assign resp_taken = is_wr_q ? axil_in.bready : axil_in.rready;

	assign axil_out.bvalid = resp_valid & is_wr_q;
	assign axil_out.bresp = resp_ok ? OKAY : SLVERR;
	assign axil_out.rvalid = resp_valid & ~is_wr_q;
	assign axil_out.rresp = resp_ok ? OKAY : SLVERR;
	// zero-extended bus word
	assign axil_out.rdata = {{(`AXIL_DW - 16){1'b0}}, resp_dt};

endmodule

// File: source/mem_module.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module mem_module #(
	parameter int MODULE_NUM = 0
) (
	input  logic                    clk,
	input  logic                    rst,
	input  elwro_bus_pkg::bus_req_s req,
	output elwro_bus_pkg::bus_rsp_s rsp
);

	import elwro_bus_pkg::*;

	// one entry per segment and page
	localparam int MAP_ENTRIES = 256;
	localparam int FRAME_W = (`MODULE_FRAMES > 1) ? $clog2(`MODULE_FRAMES) : 1;
	localparam int OFFSET_W = $clog2(`FRAME_WORDS);
	localparam int STORE_WORDS = `MODULE_FRAMES * `FRAME_WORDS;

	// page map
	logic [MAP_ENTRIES-1:0] map_valid;
	logic [FRAME_W-1:0] map_frame [MAP_ENTRIES];
	// frame storage, frames laid out back to back
	logic [15:0] store [STORE_WORDS];

	mem_addr_s mem_ad;
	cfg_cmd_s cfg_ad;
	cfg_data_s cfg_dt;
	logic [7:0] mem_idx;
	logic [7:0] cfg_idx;
	logic [FRAME_W+OFFSET_W-1:0] word_addr;
	logic mem_hit;
	logic cfg_hit;
	logic ok_q;
	logic [15:0] dt_q;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------

	// same address word, two readings
	assign mem_ad = req.ad.mem;
	assign cfg_ad = req.ad.cfg;
	assign cfg_dt = cfg_data_s'(req.dt);

	// map index is segment then page
	assign mem_idx = {req.nb, mem_ad.page};
	assign cfg_idx = {cfg_dt.segment, cfg_dt.page};

	// frame from the map on top of the offset
	assign word_addr = {map_frame[mem_idx], mem_ad.offset};

	// memory cycle answered only for a mapped page
	assign mem_hit = req.strobe & ~req.io & (req.r | req.w) & map_valid[mem_idx];

	// config write, own module number and an existing frame
	assign cfg_hit = req.strobe & req.io & req.w &
		(int'(cfg_ad.module_num) == MODULE_NUM) &
		(int'(cfg_ad.frame_num) < `MODULE_FRAMES);

	// --------------------------------------------------
	// page map
	// --------------------------------------------------

	// rewriting the entry drops any older mapping of that page
	always_ff @(posedge clk) begin
		if (rst) begin
			map_valid <= '0;
		end else if (cfg_hit) begin
			map_valid[cfg_idx] <= ~cfg_ad.unmap;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_hit & ~cfg_ad.unmap) begin
			map_frame[cfg_idx] <= cfg_ad.frame_num[FRAME_W-1:0];
		end
	end

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	// read data is zero for anything but an answered read
	always_ff @(posedge clk) begin
		if (mem_hit & req.w) begin
			store[word_addr] <= req.dt;
		end
		dt_q <= (mem_hit & req.r) ? store[word_addr] : '0;
	end

	// --------------------------------------------------
	// answer
	// --------------------------------------------------

	// ok one clock after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			ok_q <= 1'b0;
		end else begin
			ok_q <= mem_hit | cfg_hit;
		end
	end

	assign rsp = '{ok: ok_q, dt: dt_q};

endmodule

// File: source/bus_reply.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module bus_reply (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    strobe,
	input  elwro_bus_pkg::bus_rsp_s rsp_all [`N_MODULES],
	output logic                    done,
	output logic                    ok,
	output logic [15:0]             dt
);

	localparam int CNT_W = $clog2(`BUS_TIMEOUT + 1);

	logic [`N_MODULES-1:0] ok_vec;
	logic [15:0] dt_or;
	logic any_ok;
	logic conflict;
	logic timeout;
	logic wait_end;
	logic pending;
	// cycles since the strobe
	logic [CNT_W-1:0] wait_cnt;

	// --------------------------------------------------
	// merge
	// --------------------------------------------------

	// wired-or of all answers
	always_comb begin
		dt_or = '0;
		for (int i = 0; i < `N_MODULES; i++) begin
			ok_vec[i] = rsp_all[i].ok;
			dt_or = dt_or | rsp_all[i].dt;
		end
	end

	assign any_ok = |ok_vec;
	// more than one bit set
	assign conflict = |(ok_vec & (ok_vec - 1'b1));
	assign timeout = (wait_cnt == CNT_W'(`BUS_TIMEOUT));
	assign wait_end = pending & (any_ok | timeout);

	// --------------------------------------------------
	// wait and alarm
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			wait_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= wait_end;
			if (strobe) begin
				pending <= 1'b1;
				wait_cnt <= CNT_W'(1);
			end else if (wait_end) begin
				pending <= 1'b0;
				wait_cnt <= '0;
			end else if (pending) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// a clash counts as no answer, data dropped
	always_ff @(posedge clk) begin
		if (wait_end) begin
			ok <= any_ok & ~conflict;
			dt <= conflict ? '0 : dt_or;
		end
	end

endmodule

// File: source/mera_bus_top.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module mera_bus_top (
	input  logic                clk,
	input  logic                rst,
	input  axil_pkg::axil_req_s axil_in,
	output axil_pkg::axil_rsp_s axil_out
);

	import elwro_bus_pkg::*;

	// system bus
	bus_req_s bus_req;
	bus_rsp_s bus_rsp [`N_MODULES];
	// collector result
	logic rsp_done;
	logic rsp_ok;
	logic [15:0] rsp_dt;

	// --------------------------------------------------
	// bus drivers
	// --------------------------------------------------

	bus_master master0 (
		.clk(clk),
		.rst(rst),
		.axil_in(axil_in),
		.axil_out(axil_out),
		.req(bus_req),
		.rsp_done(rsp_done),
		.rsp_ok(rsp_ok),
		.rsp_dt(rsp_dt)
	);

	// --------------------------------------------------
	// memory
	// --------------------------------------------------

	// every module sees the same cycle
	for (genvar i = 0; i < `N_MODULES; i++) begin : g_mem
		mem_module #(.MODULE_NUM(i)) mem (
			.clk(clk),
			.rst(rst),
			.req(bus_req),
			.rsp(bus_rsp[i])
		);
	end

	// --------------------------------------------------
	// answers
	// --------------------------------------------------

	bus_reply reply0 (
		.clk(clk),
		.rst(rst),
		.strobe(bus_req.strobe),
		.rsp_all(bus_rsp),
		.done(rsp_done),
		.ok(rsp_ok),
		.dt(rsp_dt)
	);

endmodule

// File: verification/tb_mera_bus_assert.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module tb_mera_bus_assert (
	input logic                    clk,
	input logic                    rst,
	input elwro_bus_pkg::bus_req_s bus_req,
	input elwro_bus_pkg::bus_rsp_s bus_rsp [`N_MODULES],
	input axil_pkg::axil_req_s     axil_in,
	input axil_pkg::axil_rsp_s     axil_out
);

	logic [`N_MODULES-1:0] ok_vec;
	// strobe issued, response not yet taken
	logic pending;
	logic seen_strobe;
	int fail_cnt = 0;

	always_comb begin
		for (int i = 0; i < `N_MODULES; i++)
			ok_vec[i] = bus_rsp[i].ok;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			seen_strobe <= 1'b0;
		end else if (bus_req.strobe) begin
			pending <= 1'b1;
			seen_strobe <= 1'b1;
		end else if ((axil_out.bvalid & axil_in.bready) | (axil_out.rvalid & axil_in.rready)) begin
			pending <= 1'b0;
		end
	end

	// --------------------------------------------------
	// bus side
	// --------------------------------------------------

	one_answer: assert property (@(posedge clk) disable iff (rst) $onehot0(ok_vec))
		else begin
			$error("more than one module answered");
			fail_cnt++;
		end

	strobe_short: assert property (@(posedge clk) disable iff (rst)
		bus_req.strobe |=> !bus_req.strobe)
		else begin
			$error("bus strobe longer than one cycle");
			fail_cnt++;
		end

	strobe_alone: assert property (@(posedge clk) disable iff (rst)
		bus_req.strobe |-> !pending)
		else begin
			$error("bus strobe while a cycle is pending");
			fail_cnt++;
		end

	// nothing mapped or addressed yet
	quiet_start: assert property (@(posedge clk) disable iff (rst)
		!seen_strobe |-> (ok_vec == '0))
		else begin
			$error("module answered before any strobe");
			fail_cnt++;
		end

	// --------------------------------------------------
	// AXI side
	// --------------------------------------------------

	b_hold: assert property (@(posedge clk) disable iff (rst)
		(axil_out.bvalid && !axil_in.bready) |=> (axil_out.bvalid && $stable(axil_out.bresp)))
		else begin
			$error("write response dropped or changed before bready");
			fail_cnt++;
		end

	r_hold: assert property (@(posedge clk) disable iff (rst)
		(axil_out.rvalid && !axil_in.rready) |=>
		(axil_out.rvalid && $stable(axil_out.rresp) && $stable(axil_out.rdata)))
		else begin
			$error("read response dropped or changed before rready");
			fail_cnt++;
		end

endmodule

bind mera_bus_top tb_mera_bus_assert assert0 (
	.clk(clk),
	.rst(rst),
	.bus_req(bus_req),
	.bus_rsp(bus_rsp),
	.axil_in(axil_in),
	.axil_out(axil_out)
);

// File: verification/tb_mera_bus.sv
`timescale 1ns/1ps
`include "mera_consts.svh"

module tb_mera_bus;

	import axil_pkg::*;
	import elwro_bus_pkg::*;

	localparam int PERIOD = 40;
	localparam int HOLD_MAX = 6;
	// accesses per test
	localparam int N_EMPTY = 16;
	localparam int N_CFG = 16;
	localparam int N_PAIRS = 6;
	localparam int N_MEM = 40;
	localparam int N_REMAP = 4;
	localparam int N_IORD = 8;
	localparam int N_BP = 20;
	// each mapping may first unmap the page in every other module
	localparam int N_ACCESS = N_EMPTY + N_MEM + N_IORD + N_BP + 3 * N_REMAP
		+ (N_CFG + N_PAIRS + 2 * N_REMAP) * (`N_MODULES + 1);

	logic clk;
	logic rst;
	axil_req_s axil_req;
	axil_rsp_s axil_rsp;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	// page maps, index is segment then page
	logic map_v [`N_MODULES][256];
	int map_f [`N_MODULES][256];
	// word contents keyed by module, frame and offset
	logic [15:0] words [int];
	// mapped segment/page pairs used by the memory tests
	int pairs [$];

	string test_name;
	int n_tests;
	int n_checks;
	int n_errors;
	int test_errors;

	mera_bus_top dut0 (
		.clk(clk),
		.rst(rst),
		.axil_in(axil_req),
		.axil_out(axil_rsp)
	);

	always #(PERIOD / 2) clk = ~clk;

	// run limit from the access count, doubled for margin
	initial begin
		#(PERIOD * (N_ACCESS * (`BUS_TIMEOUT + 10 + HOLD_MAX) * 2 + 100));
		$display("watchdog expired, an access never completed");
		$display("Some tests failed");
		$finish;
	end

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (act === exp) else begin
			$display("FAILED %s: %s expected %0h, actual %0h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	function automatic int owner(input logic [3:0] seg, input logic [3:0] page);
		int found;
		found = -1;
		for (int m = 0; m < `N_MODULES; m++) begin
			if (map_v[m][{seg, page}])
				found = m;
		end
		return found;
	endfunction

	function automatic int word_key(input int m, input int f, input logic [11:0] off);
		return (m << 16) | (f << 12) | int'(off);
	endfunction

	// --------------------------------------------------
	// AXI driver
	// --------------------------------------------------

	// hold = cycles the response waits before ready, 0 keeps ready high
	task automatic axil_access(input logic is_wr, input logic [31:0] addr,
		input logic [15:0] wdata, input int hold,
		output logic [1:0] resp, output logic [31:0] rdata, output int lat);
		@(posedge clk);
		#1;
		if (is_wr) begin
			axil_req.awaddr = addr;
			axil_req.wdata = {16'h0, wdata};
			axil_req.awvalid = 1'b1;
			axil_req.wvalid = 1'b1;
		end else begin
			axil_req.araddr = addr;
			axil_req.arvalid = 1'b1;
		end
		// ready seen mid-cycle, handshake on the next edge
		do begin
			@(negedge clk);
		end while (!(is_wr ? (axil_rsp.awready & axil_rsp.wready) : axil_rsp.arready));
		@(posedge clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		axil_req.arvalid = 1'b0;
		axil_req.bready = (hold == 0);
		axil_req.rready = (hold == 0);
		// cycles from handshake edge to first valid
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!(is_wr ? axil_rsp.bvalid : axil_rsp.rvalid));
		resp = is_wr ? axil_rsp.bresp : axil_rsp.rresp;
		rdata = axil_rsp.rdata;
		repeat (hold) begin
			@(negedge clk);
			check_eq("held valid", 1, is_wr ? axil_rsp.bvalid : axil_rsp.rvalid);
			check_eq("held resp", resp, is_wr ? axil_rsp.bresp : axil_rsp.rresp);
			check_eq("held rdata", rdata, axil_rsp.rdata);
		end
		if (hold > 0) begin
			@(posedge clk);
			#1;
			axil_req.bready = 1'b1;
			axil_req.rready = 1'b1;
		end
		@(posedge clk);
		#1;
		axil_req.bready = 1'b0;
		axil_req.rready = 1'b0;
	endtask

	task automatic expect_resp(input logic answered, input logic [1:0] resp, input int lat);
		check_eq("resp", answered ? OKAY : SLVERR, resp);
		check_eq("latency", answered ? 3 : `BUS_TIMEOUT + 2, lat);
	endtask

	// --------------------------------------------------
	// checked accesses
	// --------------------------------------------------

	task automatic mem_access(input logic is_wr, input logic [3:0] nb, input logic [3:0] page,
		input logic [11:0] off, input logic [15:0] wdata, input int hold);
		logic [1:0] resp;
		logic [31:0] rdata;
		int lat;
		int m;
		int key;
		m = owner(nb, page);
		key = (m < 0) ? -1 : word_key(m, map_f[m][{nb, page}], off);
		axil_access(is_wr, {9'h0, 1'b0, nb, page, off, 2'b00}, wdata, hold, resp, rdata, lat);
		expect_resp(m >= 0, resp, lat);
		if (is_wr && m >= 0)
			words[key] = wdata;
		// storage starts unknown, so only known words are compared
		if (!is_wr) begin
			if (m < 0) begin
				check_eq("rdata", 0, rdata);
			end else if (words.exists(key)) begin
				check_eq("rdata", {16'h0, words[key]}, rdata);
			end
		end
	endtask

	task automatic cfg_write(input logic [3:0] m, input logic [3:0] f, input logic unmap,
		input logic [3:0] seg, input logic [3:0] page);
		logic [1:0] resp;
		logic [31:0] rdata;
		int lat;
		logic hit;
		hit = (m < `N_MODULES) && (f < `MODULE_FRAMES);
		// nb means nothing to a config cycle
		axil_access(1'b1, {9'h0, 1'b1, 4'($urandom), m, f, unmap, 7'h0, 2'b00},
			{seg, page, 8'h0}, 0, resp, rdata, lat);
		expect_resp(hit, resp, lat);
		if (hit) begin
			map_v[m][{seg, page}] = ~unmap;
			if (!unmap)
				map_f[m][{seg, page}] = f;
		end
	endtask

	// one owner per page, so clear it elsewhere first
	task automatic map_page(input int m, input int f, input logic [3:0] seg,
		input logic [3:0] page);
		for (int o = 0; o < `N_MODULES; o++) begin
			if (o != m && map_v[o][{seg, page}])
				cfg_write(o, 0, 1'b1, seg, page);
		end
		cfg_write(m, f, 1'b0, seg, page);
	endtask

	task automatic io_read(input logic [21:0] low, input int hold);
		logic [1:0] resp;
		logic [31:0] rdata;
		int lat;
		axil_access(1'b0, {9'h0, 1'b1, low}, 16'h0, hold, resp, rdata, lat);
		expect_resp(1'b0, resp, lat);
		check_eq("rdata", 0, rdata);
	endtask

	task automatic finish_test();
		n_tests++;
		n_errors += test_errors;
		$display("test %-14s done, %0d errors", test_name, test_errors);
		test_errors = 0;
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------

	initial begin
		int p;
		int m;
		int f;
		logic [3:0] s;
		logic [3:0] pg;
		logic [11:0] off;
		void'($urandom(32'hf5a2d9ae));
		clk = 1'b0;
		rst = 1'b1;
		axil_req = '0;
		axil_req.wstrb = '1;
		for (int i = 0; i < `N_MODULES; i++) begin
			for (int j = 0; j < 256; j++) begin
				map_v[i][j] = 1'b0;
				map_f[i][j] = 0;
			end
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		test_name = "empty_map";
		for (int i = 0; i < N_EMPTY; i++)
			mem_access($urandom_range(0, 1), 4'($urandom), 4'($urandom), 12'($urandom),
				16'($urandom), 0);
		finish_test();

		test_name = "config";
		for (int i = 0; i < N_CFG; i++) begin
			if ($urandom_range(0, 1)) begin
				map_page($urandom_range(0, `N_MODULES - 1), $urandom_range(0, `MODULE_FRAMES - 1),
					4'($urandom), 4'($urandom));
			end else if ($urandom_range(0, 1)) begin
				// absent module
				cfg_write($urandom_range(`N_MODULES, 15), $urandom_range(0, `MODULE_FRAMES - 1),
					1'b0, 4'($urandom), 4'($urandom));
			end else begin
				// frame past the end
				cfg_write($urandom_range(0, `N_MODULES - 1), $urandom_range(`MODULE_FRAMES, 15),
					1'b0, 4'($urandom), 4'($urandom));
			end
		end
		finish_test();

		// segment 15 page 15 stays free as scratch
		test_name = "mapped_mem";
		for (int i = 0; i < N_PAIRS; i++) begin
			p = {4'($urandom_range(0, 14)), 4'($urandom)};
			pairs.push_back(p);
			map_page($urandom_range(0, `N_MODULES - 1), $urandom_range(0, `MODULE_FRAMES - 1),
				p[7:4], p[3:0]);
		end
		for (int i = 0; i < N_MEM; i++) begin
			p = pairs[$urandom_range(0, N_PAIRS - 1)];
			mem_access($urandom_range(0, 1), p[7:4], p[3:0], 12'($urandom_range(0, 7)),
				16'($urandom), 0);
		end
		finish_test();

		test_name = "map_change";
		for (int i = 0; i < N_REMAP; i++) begin
			p = pairs[$urandom_range(0, N_PAIRS - 1)];
			s = p[7:4];
			pg = p[3:0];
			m = owner(s, pg);
			f = map_f[m][p];
			off = 12'($urandom_range(0, 7));
			cfg_write(m, f, 1'b1, s, pg);
			mem_access(1'b0, s, pg, off, 16'h0, 0);
			// fill the other frame through scratch, then move the page there
			map_page(m, (f + 1) % `MODULE_FRAMES, 4'hf, 4'hf);
			mem_access(1'b1, 4'hf, 4'hf, off, 16'($urandom), 0);
			map_page(m, (f + 1) % `MODULE_FRAMES, s, pg);
			mem_access(1'b0, s, pg, off, 16'h0, 0);
		end
		finish_test();

		test_name = "io_read";
		for (int i = 0; i < N_IORD; i++)
			io_read(22'($urandom), 0);
		finish_test();

		test_name = "back_pressure";
		for (int i = 0; i < N_BP; i++) begin
			p = pairs[$urandom_range(0, N_PAIRS - 1)];
			if (i % 5 == 4)
				io_read(22'($urandom), $urandom_range(1, HOLD_MAX));
			else
				mem_access($urandom_range(0, 1), p[7:4], p[3:0], 12'($urandom_range(0, 7)),
					16'($urandom), $urandom_range(1, HOLD_MAX));
		end
		finish_test();

		if (dut0.assert0.fail_cnt != 0)
			$display("bus protocol assertions failed %0d times", dut0.assert0.fail_cnt);
		n_errors += dut0.assert0.fail_cnt;
		$display("%0d tests, %0d checks, %0d failed", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/elwro_bus_pkg.sv
source/axil_pkg.sv
source/bus_master.sv
source/mem_module.sv
source/bus_reply.sv
source/mera_bus_top.sv
verification/tb_mera_bus_assert.sv
verification/tb_mera_bus.sv

// File: Bender.yml
package:
  name: mera_bus

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/elwro_bus_pkg.sv
      - source/axil_pkg.sv
      - source/bus_master.sv
      - source/mem_module.sv
      - source/bus_reply.sv
      - source/mera_bus_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_mera_bus_assert.sv
      - verification/tb_mera_bus.sv
